//--- source/sink_macros.svh
`ifndef SINK_MACROS_SVH
`define SINK_MACROS_SVH

// item, word and store counters, wrap at 2**16
`define SINK_TRANS_CNT 16

// address decoupling between generator and store port
`define SINK_FIFO_DEPTH 2
`define SINK_FIFO_PTR_W 1

// register block
`define SINK_REG_AW 3
`define SINK_RUN_CNT_W 8

`endif

//--- source/mem_port_pkg.sv
`default_nettype none

// widths of the accelerator stream and of the memory store port
package mem_port_pkg;

  // byte address, the low two bits select the lane in the wide word
  typedef logic [31:0] mem_addr_t;

  // memory word is 32 bits wider than the stream
  // so a shifted item never spills into a second word
  typedef logic [63:0] mem_data_t;
  typedef logic [7:0]  mem_be_t;      // one enable per memory byte

  // stream side coming from the datapath
  typedef logic [31:0] stream_data_t;
  typedef logic [3:0]  stream_strb_t; // one strobe per stream byte

endpackage

`default_nettype wire

//--- source/sink_ctrl_pkg.sv
`default_nettype none
`include "sink_macros.svh"

// control plane types shared by registers, generator and streamer
package sink_ctrl_pkg;

  typedef enum logic [1:0] {
    IDLE    = 2'd0,  // waiting for start
    WORKING = 2'd1,  // generator still producing addresses
    DRAIN   = 2'd2   // all addresses out, stores still outstanding
  } sink_state_e;

  // register map, word offsets
  typedef enum logic [`SINK_REG_AW-1:0] {
    REG_BASE        = 3'd0,
    REG_WORD_STRIDE = 3'd1,  // byte step inside a line
    REG_LINE_LEN    = 3'd2,  // items per line
    REG_LINE_STRIDE = 3'd3,  // byte step between line starts
    REG_TOT_LEN     = 3'd4,  // items per run
    REG_CMD         = 3'd5,  // bit 0 start, bit 1 soft clear
    REG_STATUS      = 3'd6   // bit 0 idle, 15:8 completed runs
  } reg_addr_e;

  typedef struct packed {
    mem_port_pkg::mem_addr_t    base;
    mem_port_pkg::mem_addr_t    word_stride;
    logic [`SINK_TRANS_CNT-1:0] line_len;
    mem_port_pkg::mem_addr_t    line_stride;
    logic [`SINK_TRANS_CNT-1:0] tot_len;
  } sink_cfg_t;

endpackage

`default_nettype wire

//--- source/sink_addrgen.sv
`timescale 1ns/1ps
`default_nettype none
`include "sink_macros.svh"

// two-dimensional byte address walker
// address = base + line offset + word offset
module sink_addrgen (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  logic                     en_i,
  input  sink_ctrl_pkg::sink_cfg_t cfg_i,
  output logic                     addr_valid_o,
  output mem_port_pkg::mem_addr_t  addr_o,
  input  logic                     addr_ready_i,
  output logic                     done_o
);

  logic [`SINK_TRANS_CNT-1:0] word_cnt_q;  // position within current line
  logic [`SINK_TRANS_CNT-1:0] item_cnt_q;  // addresses pushed in this run
  mem_port_pkg::mem_addr_t    line_off_q;  // start of current line, rel. to base
  mem_port_pkg::mem_addr_t    word_off_q;  // offset inside current line
  logic                       done_q;
  logic                       step;
  logic                       line_end;
  logic                       last_item;

  assign step      = addr_valid_o & addr_ready_i;  // FIFO took the address
  assign line_end  = (word_cnt_q == cfg_i.line_len - `SINK_TRANS_CNT'd1);
  assign last_item = (item_cnt_q == cfg_i.tot_len - `SINK_TRANS_CNT'd1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_cnt_q <= '0;
      item_cnt_q <= '0;
      line_off_q <= '0;
      word_off_q <= '0;
      done_q     <= 1'b0;
    end else if (clear_i) begin
      // back to the first address of the pattern
      word_cnt_q <= '0;
      item_cnt_q <= '0;
      line_off_q <= '0;
      word_off_q <= '0;
      done_q     <= 1'b0;
    end else if (step) begin
      item_cnt_q <= item_cnt_q + `SINK_TRANS_CNT'd1;
      if (last_item) begin
        done_q <= 1'b1;  // sticky until clear
      end
      if (line_end) begin
        // wrap to the next line start
        word_cnt_q <= '0;
        word_off_q <= '0;
        line_off_q <= line_off_q + cfg_i.line_stride;
      end else begin
        word_cnt_q <= word_cnt_q + `SINK_TRANS_CNT'd1;
        word_off_q <= word_off_q + cfg_i.word_stride;
      end
    end
  end

  // offered as soon as enabled, no pipeline bubble
  assign addr_valid_o = en_i & ~done_q;
  assign addr_o       = cfg_i.base + line_off_q + word_off_q;
  assign done_o       = done_q;  // level, last address pushed

endmodule

`default_nettype wire

//--- source/sink_addr_fifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "sink_macros.svh"

// small circular buffer of store addresses
module sink_addr_fifo (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    push_valid_i,
  input  mem_port_pkg::mem_addr_t push_data_i,
  output logic                    push_ready_o,
  output logic                    pop_valid_o,
  output mem_port_pkg::mem_addr_t pop_data_o,
  input  logic                    pop_ready_i
);

  mem_port_pkg::mem_addr_t    mem_q [`SINK_FIFO_DEPTH];  // queued store addresses
  logic [`SINK_FIFO_PTR_W-1:0] wr_ptr_q;
  logic [`SINK_FIFO_PTR_W-1:0] rd_ptr_q;
  logic [`SINK_FIFO_PTR_W:0]   level_q;   // one bit wider than the pointers
  logic                        push;
  logic                        pop;

  assign push_ready_o = (level_q != `SINK_FIFO_DEPTH);
  assign pop_valid_o  = (level_q != '0);
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;  // drop anything queued
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at the power-of-two depth
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        level_q <= level_q + 1'b1;
      end else if (pop && !push) begin
        level_q <= level_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // a push refused by a full buffer is offered again with the same address
  a_full_holds_push : assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    push_valid_i && !push_ready_o |=> push_valid_i && $stable(push_data_i));

endmodule

`default_nettype wire

//--- source/sink_streamer.sv
`timescale 1ns/1ps
`default_nettype none
`include "sink_macros.svh"

// pairs addresses with stream items and drives the store port
module sink_streamer (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       clear_i,
  input  logic                       start_i,
  input  sink_ctrl_pkg::sink_cfg_t   cfg_i,
  input  logic                       gen_done_i,
  output logic                       gen_en_o,
  output logic                       gen_clr_o,
  input  logic                       addr_valid_i,
  input  mem_port_pkg::mem_addr_t    addr_i,
  output logic                       addr_ready_o,
  input  logic                       stream_valid_i,
  input  mem_port_pkg::stream_data_t stream_data_i,
  input  mem_port_pkg::stream_strb_t stream_strb_i,
  output logic                       stream_ready_o,
  output logic                       mem_req_o,
  output mem_port_pkg::mem_addr_t    mem_addr_o,
  output mem_port_pkg::mem_be_t      mem_be_o,
  output mem_port_pkg::mem_data_t    mem_wdata_o,
  input  logic                       mem_gnt_i,
  output logic                       done_o,
  output logic                       idle_o
);

  sink_ctrl_pkg::sink_state_e cs, ns;
  logic [`SINK_TRANS_CNT-1:0] store_cnt_q;  // accepted stores this run
  logic                       busy;
  logic                       store;
  logic                       run_clr;      // end of run, rewind generator
  mem_port_pkg::mem_data_t    data_wide;
  mem_port_pkg::mem_be_t      strb_wide;

  assign busy   = (cs != sink_ctrl_pkg::IDLE);
  assign idle_o = ~busy;

  // misalignment shifter, item moves up by addr[1:0] bytes
  assign data_wide   = {32'h0, stream_data_i};
  assign strb_wide   = {4'h0, stream_strb_i};
  assign mem_wdata_o = data_wide << {addr_i[1:0], 3'b000};
  assign mem_be_o    = strb_wide << addr_i[1:0];
  assign mem_addr_o  = {addr_i[31:2], 2'b00};  // word aligned

  // request needs both an address and an item
  assign mem_req_o      = busy & stream_valid_i & addr_valid_i;
  assign stream_ready_o = busy & addr_valid_i & mem_gnt_i;  // low while gnt low
  assign addr_ready_o   = stream_valid_i & stream_ready_o;  // pop with the item
  assign store          = mem_req_o & mem_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cs <= sink_ctrl_pkg::IDLE;
    end else if (clear_i) begin
      cs <= sink_ctrl_pkg::IDLE;  // soft clear wins over everything
    end else begin
      cs <= ns;
    end
  end

  always_comb begin
    ns       = cs;
    gen_en_o = 1'b0;
    run_clr  = 1'b0;
    done_o   = 1'b0;
    case (cs)
      sink_ctrl_pkg::IDLE: begin
        if (start_i) begin
          ns       = sink_ctrl_pkg::WORKING;
          gen_en_o = 1'b1;  // first address already in the start cycle
        end
      end
      sink_ctrl_pkg::WORKING: begin
        gen_en_o = 1'b1;
        if (gen_done_i) begin
          ns = sink_ctrl_pkg::DRAIN;
        end
      end
      sink_ctrl_pkg::DRAIN: begin
        gen_en_o = 1'b1;
        if (store_cnt_q == cfg_i.tot_len) begin
          ns       = sink_ctrl_pkg::IDLE;
          gen_en_o = 1'b0;
          run_clr  = 1'b1;
          done_o   = 1'b1;  // single cycle, state leaves DRAIN
        end
      end
      default: begin
        ns = sink_ctrl_pkg::IDLE;
      end
    endcase
  end

  assign gen_clr_o = clear_i | run_clr;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      store_cnt_q <= '0;
    end else if (clear_i || run_clr) begin
      store_cnt_q <= '0;
    end else if (store) begin
      store_cnt_q <= store_cnt_q + `SINK_TRANS_CNT'd1;
    end
  end

  // an ungranted store holds its request, relies on FIFO and stream stability
  a_req_stable : assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_addr_o)
      && $stable(mem_be_o) && $stable(mem_wdata_o));

  // an idle streamer has no address queued, so nothing can request
  a_idle_quiet : assert property (@(posedge clk_i) disable iff (!rst_ni)
    cs == sink_ctrl_pkg::IDLE |-> !addr_valid_i && !mem_req_o);

endmodule

`default_nettype wire

//--- source/sink_regfile.sv
`timescale 1ns/1ps
`default_nettype none
`include "sink_macros.svh"

// pattern registers, command decode and status
module sink_regfile (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     reg_we_i,
  input  logic [`SINK_REG_AW-1:0]  reg_addr_i,
  input  logic [31:0]              reg_wdata_i,
  output logic [31:0]              reg_rdata_o,
  output sink_ctrl_pkg::sink_cfg_t cfg_o,
  output logic                     start_o,
  output logic                     clear_o,
  input  logic                     done_i,
  input  logic                     idle_i
);

  sink_ctrl_pkg::sink_cfg_t   cfg_q;
  sink_ctrl_pkg::reg_addr_e   reg_sel;
  logic                       cmd_wr;
  logic                       start_q;
  logic                       clear_q;
  logic [`SINK_RUN_CNT_W-1:0] run_cnt_q;  // completed runs, wraps

  assign reg_sel = sink_ctrl_pkg::reg_addr_e'(reg_addr_i);
  assign cmd_wr  = reg_we_i & (reg_sel == sink_ctrl_pkg::REG_CMD);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q <= '0;
    end else if (reg_we_i) begin
      case (reg_sel)
        sink_ctrl_pkg::REG_BASE:        cfg_q.base        <= reg_wdata_i;
        sink_ctrl_pkg::REG_WORD_STRIDE: cfg_q.word_stride <= reg_wdata_i;
        sink_ctrl_pkg::REG_LINE_LEN:    cfg_q.line_len    <= reg_wdata_i[`SINK_TRANS_CNT-1:0];
        sink_ctrl_pkg::REG_LINE_STRIDE: cfg_q.line_stride <= reg_wdata_i;
        sink_ctrl_pkg::REG_TOT_LEN:     cfg_q.tot_len     <= reg_wdata_i[`SINK_TRANS_CNT-1:0];
        default: begin
          cfg_q <= cfg_q;  // cmd and status leave the pattern alone
        end
      endcase
    end
  end

  // command pulses, registered, high for one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q <= 1'b0;
      clear_q <= 1'b0;
    end else begin
      start_q <= cmd_wr & reg_wdata_i[0];
      clear_q <= cmd_wr & reg_wdata_i[1];
    end
  end

  // only a hard reset rewinds the run count
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      run_cnt_q <= '0;
    end else if (done_i) begin
      run_cnt_q <= run_cnt_q + `SINK_RUN_CNT_W'd1;
    end
  end

  assign cfg_o   = cfg_q;
  assign start_o = start_q;
  assign clear_o = clear_q;

  // read mux, combinational
  always_comb begin
    case (reg_sel)
      sink_ctrl_pkg::REG_BASE:        reg_rdata_o = cfg_q.base;
      sink_ctrl_pkg::REG_WORD_STRIDE: reg_rdata_o = cfg_q.word_stride;
      sink_ctrl_pkg::REG_LINE_LEN: begin
        reg_rdata_o = {{(32-`SINK_TRANS_CNT){1'b0}}, cfg_q.line_len};
      end
      sink_ctrl_pkg::REG_LINE_STRIDE: reg_rdata_o = cfg_q.line_stride;
      sink_ctrl_pkg::REG_TOT_LEN: begin
        reg_rdata_o = {{(32-`SINK_TRANS_CNT){1'b0}}, cfg_q.tot_len};
      end
      sink_ctrl_pkg::REG_STATUS: begin
        reg_rdata_o = {16'h0, run_cnt_q, 7'h0, idle_i};
      end
      default: begin
        reg_rdata_o = '0;  // cmd reads back zero
      end
    endcase
  end

endmodule

`default_nettype wire

//--- source/store_sink_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "sink_macros.svh"

// store sink, registers + address generator + FIFO + streamer
module store_sink_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       reg_we_i,
  input  logic [`SINK_REG_AW-1:0]    reg_addr_i,
  input  logic [31:0]                reg_wdata_i,
  output logic [31:0]                reg_rdata_o,
  input  logic                       stream_valid_i,
  input  mem_port_pkg::stream_data_t stream_data_i,
  input  mem_port_pkg::stream_strb_t stream_strb_i,
  output logic                       stream_ready_o,
  output logic                       mem_req_o,
  output mem_port_pkg::mem_addr_t    mem_addr_o,
  output mem_port_pkg::mem_be_t      mem_be_o,
  output mem_port_pkg::mem_data_t    mem_wdata_o,
  input  logic                       mem_gnt_i,
  output logic                       done_o
);

  sink_ctrl_pkg::sink_cfg_t cfg;
  logic                     start;
  logic                     soft_clear;
  logic                     idle;
  logic                     gen_en;
  logic                     gen_clr;   // soft clear or end of run
  logic                     gen_done;
  logic                     push_valid;
  logic                     push_ready;
  mem_port_pkg::mem_addr_t  push_addr;
  logic                     pop_valid;
  logic                     pop_ready;
  mem_port_pkg::mem_addr_t  pop_addr;

  sink_regfile i_regfile (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .reg_we_i    ( reg_we_i    ),
    .reg_addr_i  ( reg_addr_i  ),
    .reg_wdata_i ( reg_wdata_i ),
    .reg_rdata_o ( reg_rdata_o ),
    .cfg_o       ( cfg         ),
    .start_o     ( start       ),
    .clear_o     ( soft_clear  ),
    .done_i      ( done_o      ),
    .idle_i      ( idle        )
  );

  sink_addrgen i_addrgen (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clear_i      ( gen_clr    ),
    .en_i         ( gen_en     ),
    .cfg_i        ( cfg        ),
    .addr_valid_o ( push_valid ),
    .addr_o       ( push_addr  ),
    .addr_ready_i ( push_ready ),
    .done_o       ( gen_done   )
  );

  sink_addr_fifo i_addr_fifo (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clear_i      ( soft_clear ),
    .push_valid_i ( push_valid ),
    .push_data_i  ( push_addr  ),
    .push_ready_o ( push_ready ),
    .pop_valid_o  ( pop_valid  ),
    .pop_data_o   ( pop_addr   ),
    .pop_ready_i  ( pop_ready  )
  );

  sink_streamer i_streamer (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( soft_clear     ),
    .start_i        ( start          ),
    .cfg_i          ( cfg            ),
    .gen_done_i     ( gen_done       ),
    .gen_en_o       ( gen_en         ),
    .gen_clr_o      ( gen_clr        ),
    .addr_valid_i   ( pop_valid      ),
    .addr_i         ( pop_addr       ),
    .addr_ready_o   ( pop_ready      ),
    .stream_valid_i ( stream_valid_i ),
    .stream_data_i  ( stream_data_i  ),
    .stream_strb_i  ( stream_strb_i  ),
    .stream_ready_o ( stream_ready_o ),
    .mem_req_o      ( mem_req_o      ),
    .mem_addr_o     ( mem_addr_o     ),
    .mem_be_o       ( mem_be_o       ),
    .mem_wdata_o    ( mem_wdata_o    ),
    .mem_gnt_i      ( mem_gnt_i      ),
    .done_o         ( done_o         ),
    .idle_o         ( idle           )
  );

endmodule

`default_nettype wire

//--- test/tb_store_sink.sv
`timescale 1ns/1ps
`default_nettype none
`include "sink_macros.svh"

module tb_store_sink;

  localparam int MEM_BYTES = 4096;
  localparam int TIMEOUT   = 1000;  // cycles per wait loop

  logic                       clk_i = 1'b0;
  logic                       rst_ni;
  logic                       reg_we_i;
  logic [`SINK_REG_AW-1:0]    reg_addr_i;
  logic [31:0]                reg_wdata_i;
  logic [31:0]                reg_rdata_o;
  logic                       stream_valid_i;
  mem_port_pkg::stream_data_t stream_data_i;
  mem_port_pkg::stream_strb_t stream_strb_i;
  logic                       stream_ready_o;
  logic                       mem_req_o;
  mem_port_pkg::mem_addr_t    mem_addr_o;
  mem_port_pkg::mem_be_t      mem_be_o;
  mem_port_pkg::mem_data_t    mem_wdata_o;
  logic                       mem_gnt_i;
  logic                       done_o;

  logic [7:0]                 mem     [MEM_BYTES];  // written by the memory model
  logic [7:0]                 exp_mem [MEM_BYTES];  // reference image
  mem_port_pkg::stream_data_t item_data [64];
  mem_port_pkg::stream_strb_t item_strb [64];
  sink_ctrl_pkg::sink_cfg_t   cfg;         // pattern as last written
  logic                       gnt_random;  // 0 means gnt always high
  logic [1:0]                 next_gap;    // fresh gap length every cycle
  int                         store_cnt;
  int                         done_cnt;
  int                         exp_runs;
  int                         run_store0;  // counters at run start
  int                         run_done0;

  store_sink_top i_store_sink_top (.*);

  always #5 clk_i = ~clk_i;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [7:0] fill_byte(input int a);
    logic [11:0] x;
    x = a[11:0];
    return x[7:0] ^ {x[11:8], x[11:8]} ^ 8'h5a;  // every address bit matters
  endfunction

  // byte address of item k in the 2d pattern
  function automatic mem_port_pkg::mem_addr_t pattern_addr(input int k);
    int word;
    int line;
    word = k % int'(cfg.line_len);
    line = k / int'(cfg.line_len);
    return cfg.base + mem_port_pkg::mem_addr_t'(word) * cfg.word_stride
      + mem_port_pkg::mem_addr_t'(line) * cfg.line_stride;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_addr(input string name, input mem_port_pkg::mem_addr_t got,
                            input mem_port_pkg::mem_addr_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("mismatch %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_byte(input mem_port_pkg::mem_addr_t addr, input logic [7:0] got,
                            input logic [7:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("mismatch mem[0x%0h] got 0x%02h expected 0x%02h", addr, got, exp));
    end
  endtask

  task automatic check_status(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("mismatch %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      stop_on_error($sformatf("mismatch %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // gnt and stream gaps, one lfsr step per bit
  initial begin : rand_src
    logic [31:0] lfsr;
    lfsr      = 32'hfff6f067;
    mem_gnt_i = 1'b0;
    next_gap  = 2'd0;
    forever begin
      @(posedge clk_i);
      #1;
      lfsr        = lfsr_step(lfsr);
      mem_gnt_i   = gnt_random ? lfsr[0] : 1'b1;
      lfsr        = lfsr_step(lfsr);
      next_gap[0] = lfsr[0];
      lfsr        = lfsr_step(lfsr);
      next_gap[1] = lfsr[0];
    end
  end

  // byte memory, store taken on req & gnt, sampled mid-cycle
  initial begin : mem_model
    int a;
    int i;
    for (a = 0; a < MEM_BYTES; a++) begin
      mem[a] = fill_byte(a);
    end
    store_cnt = 0;
    forever begin
      @(negedge clk_i);
      if (rst_ni && mem_req_o && mem_gnt_i) begin
        if (mem_addr_o > mem_port_pkg::mem_addr_t'(MEM_BYTES - 8)) begin
          stop_on_error($sformatf("store to 0x%08h outside the memory model", mem_addr_o));
        end
        check_addr("mem_addr_o[1:0]", mem_addr_o & 32'h3, 32'h0);
        for (i = 0; i < 8; i++) begin
          if (mem_be_o[i]) mem[int'(mem_addr_o) + i] = mem_wdata_o[8*i +: 8];
        end
        store_cnt++;
      end
    end
  end

  initial begin : done_mon
    done_cnt = 0;
    forever begin
      @(negedge clk_i);
      if (done_o) done_cnt++;
    end
  end

  task automatic reg_write(input sink_ctrl_pkg::reg_addr_e a, input logic [31:0] d);
    @(posedge clk_i);
    #1;
    reg_we_i    = 1'b1;
    reg_addr_i  = a;
    reg_wdata_i = d;
    @(posedge clk_i);
    #1;
    reg_we_i = 1'b0;
  endtask

  task automatic reg_read(input sink_ctrl_pkg::reg_addr_e a, output logic [31:0] d);
    @(posedge clk_i);
    #1;
    reg_addr_i = a;
    @(negedge clk_i);
    d = reg_rdata_o;  // combinational read port
  endtask

  task automatic configure(input logic [31:0] base, input logic [31:0] wstride,
                           input logic [31:0] llen, input logic [31:0] lstride,
                           input logic [31:0] tlen);
    reg_write(sink_ctrl_pkg::REG_BASE, base);
    reg_write(sink_ctrl_pkg::REG_WORD_STRIDE, wstride);
    reg_write(sink_ctrl_pkg::REG_LINE_LEN, llen);
    reg_write(sink_ctrl_pkg::REG_LINE_STRIDE, lstride);
    reg_write(sink_ctrl_pkg::REG_TOT_LEN, tlen);
    cfg.base        = base;
    cfg.word_stride = wstride;
    cfg.line_len    = llen[`SINK_TRANS_CNT-1:0];  // counters are 16 bit
    cfg.line_stride = lstride;
    cfg.tot_len     = tlen[`SINK_TRANS_CNT-1:0];
  endtask

  task automatic prepare_items(input int count, input logic [31:0] salt, input bit vary);
    int k;
    for (k = 0; k < count; k++) begin
      item_data[k] = (32'(k) + 32'd1) * 32'h9e37_79b1 ^ salt;
      item_strb[k] = vary ? 4'(k * 7 + 3) : 4'hf;  // holes in the strobes
    end
  endtask

  // valid held with stable data until ready, optional lfsr gaps
  task automatic run_stream(input int first, input int count, input bit gaps);
    int k;
    int gap;
    int t;
    @(negedge clk_i);
    for (k = first; k < first + count; k++) begin
      gap = gaps ? int'(next_gap) : 0;
      @(posedge clk_i);
      #1;
      if (gap != 0) begin
        stream_valid_i = 1'b0;
        repeat (gap) @(posedge clk_i);
        #1;
      end
      stream_valid_i = 1'b1;
      stream_data_i  = item_data[k];
      stream_strb_i  = item_strb[k];
      t = 0;
      @(negedge clk_i);
      while (!stream_ready_o) begin
        t++;
        if (t > TIMEOUT) stop_on_error($sformatf("timeout, stream item %0d not accepted", k));
        @(negedge clk_i);
      end
    end
    @(posedge clk_i);
    #1;
    stream_valid_i = 1'b0;
  endtask

  task automatic wait_done();
    int t;
    t = 0;
    @(negedge clk_i);
    while (!done_o) begin
      t++;
      if (t > TIMEOUT) stop_on_error("timeout waiting for done_o");
      @(negedge clk_i);
    end
  endtask

  task automatic expect_items(input int count);
    int k;
    int j;
    mem_port_pkg::mem_addr_t a;
    for (k = 0; k < count; k++) begin
      a = pattern_addr(k);
      for (j = 0; j < 4; j++) begin
        if (item_strb[k][j]) exp_mem[int'(a) + j] = item_data[k][8*j +: 8];
      end
    end
  endtask

  task automatic compare_memory();
    int a;
    for (a = 0; a < MEM_BYTES; a++) begin
      check_byte(mem_port_pkg::mem_addr_t'(a), mem[a], exp_mem[a]);
    end
  endtask

  task automatic begin_run();
    run_store0 = store_cnt;
    run_done0  = done_cnt;
    reg_write(sink_ctrl_pkg::REG_CMD, 32'h1);  // start
  endtask

  task automatic finish_run(input int count);
    logic [31:0] d;
    wait_done();
    repeat (4) @(posedge clk_i);  // room for a stray second pulse
    exp_runs++;
    expect_items(count);
    reg_read(sink_ctrl_pkg::REG_STATUS, d);
    check_status("status", d, {16'h0, exp_runs[7:0], 8'h01});
    check_count("stores", store_cnt - run_store0, count);
    check_count("done pulses", done_cnt - run_done0, 1);
    compare_memory();
  endtask

  task automatic test_registers();
    logic [31:0] d;
    check_status("reset outputs", {29'h0, done_o, mem_req_o, stream_ready_o}, 32'h0);
    reg_read(sink_ctrl_pkg::REG_STATUS, d);
    check_status("status", d, 32'h1);  // idle, no runs
    configure(32'h1234_5678, 32'h10, 32'hffff_abcd, 32'hdead_0040, 32'h0003_0007);
    reg_read(sink_ctrl_pkg::REG_BASE, d);
    check_addr("base", d, 32'h1234_5678);
    reg_read(sink_ctrl_pkg::REG_WORD_STRIDE, d);
    check_addr("word_stride", d, 32'h10);
    reg_read(sink_ctrl_pkg::REG_LINE_LEN, d);
    check_status("line_len", d, 32'h0000_abcd);
    reg_read(sink_ctrl_pkg::REG_LINE_STRIDE, d);
    check_addr("line_stride", d, 32'hdead_0040);
    reg_read(sink_ctrl_pkg::REG_TOT_LEN, d);
    check_status("tot_len", d, 32'h7);
    reg_write(sink_ctrl_pkg::REG_STATUS, 32'hffff_ffff);  // read only
    reg_read(sink_ctrl_pkg::REG_STATUS, d);
    check_status("status", d, 32'h1);
  endtask

  task automatic test_aligned_linear();
    gnt_random = 1'b0;
    configure(32'h100, 32'h4, 32'd16, 32'h0, 32'd16);
    prepare_items(16, 32'h0, 1'b0);
    begin_run();
    run_stream(0, 16, 1'b0);
    finish_run(16);
  endtask

  task automatic test_misaligned();
    int off;
    gnt_random = 1'b1;
    for (off = 1; off < 4; off++) begin
      configure(32'h200 + 32'h100 * off + off, 32'h4, 32'd8, 32'h0, 32'd8);
      prepare_items(8, 32'h5500 + off, 1'b1);
      begin_run();
      run_stream(0, 8, 1'b1);
      finish_run(8);
    end
  endtask

  task automatic test_two_dim();
    gnt_random = 1'b1;
    configure(32'h600, 32'h8, 32'd3, 32'h40, 32'd10);  // last line partial
    prepare_items(10, 32'h2d00, 1'b0);
    begin_run();
    run_stream(0, 10, 1'b1);
    finish_run(10);
  endtask

  task automatic test_start_ignored();
    configure(32'h800, 32'h4, 32'd4, 32'h20, 32'd12);
    prepare_items(12, 32'h0bad, 1'b0);
    begin_run();
    run_stream(0, 4, 1'b1);
    reg_write(sink_ctrl_pkg::REG_CMD, 32'h1);  // busy, no effect
    run_stream(4, 8, 1'b1);
    finish_run(12);
  endtask

  task automatic test_soft_clear();
    logic [31:0] d;
    int t;
    configure(32'h900, 32'h4, 32'd8, 32'h0, 32'd8);
    prepare_items(8, 32'h77, 1'b0);
    begin_run();
    run_stream(0, 3, 1'b1);
    reg_write(sink_ctrl_pkg::REG_CMD, 32'h2);  // soft clear mid run
    d = 32'h0;
    t = 0;
    while (!d[0]) begin
      t++;
      if (t > 2) stop_on_error("status not idle within two cycles of soft clear");
      reg_read(sink_ctrl_pkg::REG_STATUS, d);
    end
    check_status("status", d, {16'h0, exp_runs[7:0], 8'h01});  // run not counted
    expect_items(3);
    check_count("stores before clear", store_cnt - run_store0, 3);
    check_count("done pulses", done_cnt - run_done0, 0);
    compare_memory();
    prepare_items(8, 32'h99, 1'b0);
    begin_run();
    run_stream(0, 8, 1'b1);
    finish_run(8);
  endtask

  initial begin : main
    int a;
    rst_ni         = 1'b0;
    reg_we_i       = 1'b0;
    reg_addr_i     = '0;
    reg_wdata_i    = '0;
    stream_valid_i = 1'b0;
    stream_data_i  = '0;
    stream_strb_i  = '0;
    gnt_random     = 1'b0;
    exp_runs       = 0;
    run_store0     = 0;
    run_done0      = 0;
    cfg            = '0;
    for (a = 0; a < MEM_BYTES; a++) begin
      exp_mem[a] = fill_byte(a);
    end
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    test_registers();
    test_aligned_linear();
    test_misaligned();
    test_two_dim();
    test_start_ignored();
    test_soft_clear();
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+source
source/mem_port_pkg.sv
source/sink_ctrl_pkg.sv
source/sink_addrgen.sv
source/sink_addr_fifo.sv
source/sink_streamer.sv
source/sink_regfile.sv
source/store_sink_top.sv
test/tb_store_sink.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_store_sink -f files.f \
  && ./obj_dir/Vtb_store_sink | tee /dev/stderr | grep -x "Verification passed" > /dev/null \
  && echo "run ok" \
  || { echo "run failed"; exit 1; }
